/* hdl/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // Architectural register index, x0 reads as zero and is never a real producer
  typedef logic [4:0] reg_addr_t;

  localparam reg_addr_t REG_ZERO = 5'd0;

  // Instruction class as seen by the pipeline control
  // Only the class matters here since the datapath is outside this block
  typedef enum logic [2:0] {
    OP_ALU   = 3'd0,
    OP_LOAD  = 3'd1,
    OP_STORE = 3'd2,
    OP_CSR   = 3'd3,
    OP_MUL   = 3'd4,
    OP_DIV   = 3'd5,
    OP_NOP   = 3'd6
  } op_class_e;

  // Where the result of an instruction in MEM comes from
  // Loads and stores both map to the memory source
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_CSR = 2'd2,
    RES_M   = 2'd3
  } res_src_e;

  // PC source chosen by the front end for the next fetch
  typedef enum logic [1:0] {
    PC_SEL_SEQ       = 2'd0,
    PC_SEL_PREDICTED = 2'd1,
    PC_SEL_REDIRECT  = 2'd2
  } pc_sel_e;

  // Data memory flavour
  // SRAM returns load data in MEM, BRAM only in WB
  typedef enum logic {
    MEM_TYPE_SRAM = 1'b0,
    MEM_TYPE_BRAM = 1'b1
  } mem_type_e;

endpackage

/* hdl/rv_stage_if.sv */
interface rv_stage_if
  import rv_pipe_pkg::*;
();

  // Metadata of the instruction held in one pipeline stage
  // A bubble has valid and reg_write both low
  logic      valid;
  reg_addr_t rd;
  logic      reg_write;
  op_class_e op;
  res_src_e  res_src;

  // The stage register owns the fields
  modport producer(output valid, output rd, output reg_write, output op, output res_src);

  // Hazard logic and the divide timer only look
  modport reader(input valid, input rd, input reg_write, input op, input res_src);

endinterface

/* hdl/rv_hazard.sv */
module rv_hazard
  import rv_pipe_pkg::*;
#(
  parameter int        FWD,
  parameter int        FWD_REGFILE,
  parameter mem_type_e MEM_TYPE
) (
  // Source fields of the instruction in ID
  input  reg_addr_t         rs1,
  input  reg_addr_t         rs2,
  input  logic              rs1_used,
  input  logic              rs2_used,

  // Stage contents behind ID
  rv_stage_if.reader        ex_stage,
  rv_stage_if.reader        mem_stage,
  rv_stage_if.reader        wb_stage,

  input  logic              op_active_ex,
  input  pc_sel_e           pc_sel,
  input  logic              mispredicted_mem,
  input  logic              btb_pred_taken,
  input  logic              ras_pred_taken,
  input  logic              halt,

  output logic              pc_stall,
  output logic              if_id_stall,
  output logic              if_id_flush,
  output logic              id_ex_stall,
  output logic              id_ex_flush,
  output logic              ex_mem_stall,
  output logic              ex_mem_flush
);

  logic ex_hit;
  logic mem_hit;
  logic wb_hit;
  logic slow_ex;
  logic slow_mem;
  logic data_hazard;
  logic pc_redirect;
  logic pc_predicted;
  logic pred_flush;
  logic stall_disable;
  logic front_stall;

  // True when an ID source that is really read names a live destination
  // Writes to x0 never count as producers
  function automatic logic reads_dest(input reg_addr_t src, input logic used,
                                      input reg_addr_t dst, input logic wr);
    return used && wr && (dst != REG_ZERO) && (dst == src);
  endfunction

  assign ex_hit = reads_dest(rs1, rs1_used, ex_stage.rd, ex_stage.reg_write) ||
                  reads_dest(rs2, rs2_used, ex_stage.rd, ex_stage.reg_write);

  assign mem_hit = reads_dest(rs1, rs1_used, mem_stage.rd, mem_stage.reg_write) ||
                   reads_dest(rs2, rs2_used, mem_stage.rd, mem_stage.reg_write);

  // A register file that bypasses its own write port hides WB producers
  assign wb_hit = (FWD_REGFILE == 0) &&
                  (reads_dest(rs1, rs1_used, wb_stage.rd, wb_stage.reg_write) ||
                   reads_dest(rs2, rs2_used, wb_stage.rd, wb_stage.reg_write));

  // Producers in EX whose value the forwarding paths cannot supply yet
  assign slow_ex = ex_stage.op inside {OP_LOAD, OP_CSR, OP_MUL, OP_DIV};

  // In MEM, CSR and M results are still not on a forward path
  // A load is only late there when the memory is BRAM
  assign slow_mem = (mem_stage.res_src inside {RES_CSR, RES_M}) ||
                    ((MEM_TYPE == MEM_TYPE_BRAM) && (mem_stage.res_src == RES_MEM));

  if (FWD != 0) begin : g_fwd
    // Forwarding covers ordinary ALU producers in EX and MEM
    assign data_hazard = (slow_ex && ex_hit) || (slow_mem && mem_hit) || wb_hit;
  end else begin : g_no_fwd
    // Without forwarding every RAW dependence waits for the register file
    assign data_hazard = ex_hit || mem_hit || wb_hit;
  end

  assign pc_redirect  = (pc_sel == PC_SEL_REDIRECT);
  assign pc_predicted = (pc_sel == PC_SEL_PREDICTED);

  // The consumer is discarded anyway on a redirect, so waiting for it is wasted
  assign stall_disable = pc_redirect || mispredicted_mem;
  assign front_stall   = data_hazard || op_active_ex;

  // Front of the pipe holds on a hazard or a running divide
  // Halt freezes everything up to EX/MEM
  assign pc_stall     = (front_stall && !stall_disable) || halt;
  assign if_id_stall  = (front_stall && !stall_disable) || halt;
  assign id_ex_stall  = op_active_ex || halt;
  assign ex_mem_stall = halt;

  // A BTB hit steers fetch before the fall-through is fetched and leaves nothing to drop
  // RAS and static predictions come from ID and the fall-through is already in IF
  // No flush while the front is held since the predicting instruction has not moved
  assign pred_flush = pc_predicted && (!btb_pred_taken || ras_pred_taken) &&
                      !data_hazard && !op_active_ex;

  assign if_id_flush = pc_redirect || mispredicted_mem || pred_flush;

  // Data hazards insert a bubble into EX unless a divide owns EX
  assign id_ex_flush = (data_hazard && !op_active_ex) || pc_redirect || mispredicted_mem;

  // While a divide runs, MEM receives bubbles and the divide stays put
  assign ex_mem_flush = mispredicted_mem || op_active_ex;

  // Every control is known whenever the inputs and stage valid bits are known
  ap_ctrl_known: assert final (
    $isunknown({rs1, rs2, rs1_used, rs2_used, op_active_ex, pc_sel, mispredicted_mem,
                btb_pred_taken, ras_pred_taken, halt, ex_stage.valid,
                mem_stage.valid, wb_stage.valid}) ||
    !$isunknown({pc_stall, if_id_stall, if_id_flush, id_ex_stall, id_ex_flush,
                 ex_mem_stall, ex_mem_flush}))
    else $error("stall or flush control is unknown");

endmodule

/* hdl/rv_stage_regs.sv */
module rv_stage_regs
  import rv_pipe_pkg::*;
(
  input  logic         clk,
  input  logic         reset,

  // Decoded instruction currently in ID
  input  logic         id_valid,
  input  reg_addr_t    rd,
  input  logic         reg_write,
  input  op_class_e    op,

  input  logic         pc_stall,
  input  logic         if_id_stall,
  input  logic         if_id_flush,
  input  logic         id_ex_stall,
  input  logic         id_ex_flush,
  input  logic         ex_mem_stall,
  input  logic         ex_mem_flush,

  rv_stage_if.producer ex_stage,
  rv_stage_if.producer mem_stage,
  rv_stage_if.producer wb_stage,

  output logic         retire_valid,
  output reg_addr_t    retire_rd
);

  logic id_kill;
  logic id_live;

  // Result source follows from the class alone
  function automatic res_src_e res_src_of(input op_class_e cls);
    case (cls)
      OP_LOAD, OP_STORE: return RES_MEM;
      OP_CSR:            return RES_CSR;
      OP_MUL, OP_DIV:    return RES_M;
      default:           return RES_ALU;
    endcase
  endfunction

  // Stands in for the IF/ID valid bit
  // A flush marks whatever shows up in ID next as wrong-path
  always_ff @(posedge clk) begin
    if (reset) begin
      id_kill <= 1'b0;
    end else if (if_id_flush) begin
      id_kill <= 1'b1;
    end else if (!if_id_stall) begin
      id_kill <= 1'b0;
    end
  end

  assign id_live = id_valid && !id_kill;

  // Stall has priority at ID/EX so a busy divide is never dropped
  always_ff @(posedge clk) begin
    if (reset || (id_ex_flush && !id_ex_stall)) begin
      ex_stage.valid     <= 1'b0;
      ex_stage.reg_write <= 1'b0;
      ex_stage.op        <= OP_NOP;
    end else if (!id_ex_stall) begin
      ex_stage.valid     <= id_live;
      ex_stage.reg_write <= id_live && reg_write;
      ex_stage.op        <= id_live ? op : OP_NOP;
    end
  end

  // Result source is only resolved once the class reaches MEM
  always_ff @(posedge clk) begin
    if (!id_ex_stall) begin
      ex_stage.rd      <= rd;
      ex_stage.res_src <= RES_ALU;
    end
  end

  // Flush has priority at EX/MEM so a frozen EX never reaches MEM twice
  always_ff @(posedge clk) begin
    if (reset || ex_mem_flush) begin
      mem_stage.valid     <= 1'b0;
      mem_stage.reg_write <= 1'b0;
      mem_stage.op        <= OP_NOP;
    end else if (!ex_mem_stall) begin
      mem_stage.valid     <= ex_stage.valid;
      mem_stage.reg_write <= ex_stage.reg_write;
      mem_stage.op        <= ex_stage.op;
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_mem_stall) begin
      mem_stage.rd      <= ex_stage.rd;
      mem_stage.res_src <= res_src_of(ex_stage.op);
    end
  end

  // MEM/WB keeps moving and a frozen MEM hands it bubbles
  always_ff @(posedge clk) begin
    if (reset || (ex_mem_stall && !ex_mem_flush)) begin
      wb_stage.valid     <= 1'b0;
      wb_stage.reg_write <= 1'b0;
      wb_stage.op        <= OP_NOP;
    end else begin
      wb_stage.valid     <= mem_stage.valid;
      wb_stage.reg_write <= mem_stage.reg_write;
      wb_stage.op        <= mem_stage.op;
    end
  end

  always_ff @(posedge clk) begin
    wb_stage.rd      <= mem_stage.rd;
    wb_stage.res_src <= mem_stage.res_src;
  end

  // Retire port trails WB by one cycle, which keeps retirement in order
  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= wb_stage.valid;
    end
  end

  always_ff @(posedge clk) begin
    retire_rd <= wb_stage.rd;
  end

  // Whoever feeds ID must hold the instruction while the front is stalled
  ap_id_hold: assert property (@(posedge clk) disable iff (reset)
    (pc_stall && id_valid) |=> $stable({id_valid, rd, reg_write, op}));

endmodule

/* hdl/rv_mdiv_timer.sv */
module rv_mdiv_timer
  import rv_pipe_pkg::*;
#(
  parameter int DIV_CYCLES
) (
  input  logic       clk,
  input  logic       reset,
  rv_stage_if.reader ex_stage,
  output logic       op_active_ex
);

  localparam int CNT_W = $clog2(DIV_CYCLES);

  // Remaining busy cycles minus one for the divide in EX
  logic [CNT_W-1:0] cnt;
  logic             done;
  logic             div_in_ex;

  if (DIV_CYCLES < 2 || DIV_CYCLES > 34) begin : g_bad_cycles
    $error("DIV_CYCLES must lie between 2 and 34");
  end

  assign div_in_ex = ex_stage.valid && (ex_stage.op == OP_DIV);

  // Busy from the first EX cycle until the count runs out
  assign op_active_ex = div_in_ex && !done;

  // Done lasts one cycle, the one in which the finished divide leaves EX
  // Clearing it then lets a back-to-back divide start its own count
  always_ff @(posedge clk) begin
    if (reset || !div_in_ex || done) begin
      cnt  <= CNT_W'(DIV_CYCLES - 1);
      done <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= CNT_W'(DIV_CYCLES - 1);
      done <= 1'b1;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // A single divide never holds EX longer than its latency
  ap_busy_len: assert property (@(posedge clk) disable iff (reset)
    op_active_ex [* DIV_CYCLES] |=> !op_active_ex);

endmodule

/* hdl/rv_pipe_ctrl.sv */
module rv_pipe_ctrl
  import rv_pipe_pkg::*;
#(
  parameter int        FWD         = 1,
  parameter int        FWD_REGFILE = 0,
  parameter mem_type_e MEM_TYPE    = MEM_TYPE_BRAM,
  parameter int        DIV_CYCLES  = 4
) (
  input  logic      clk,
  input  logic      reset,

  // Decoded instruction in ID
  input  logic      id_valid,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      rs1_used,
  input  logic      rs2_used,
  input  reg_addr_t rd,
  input  logic      reg_write,
  input  op_class_e op,

  // Front end and branch resolution
  input  pc_sel_e   pc_sel,
  input  logic      mispredicted_mem,
  input  logic      btb_pred_taken,
  input  logic      ras_pred_taken,
  input  logic      halt,

  output logic      pc_stall,
  output logic      if_id_stall,
  output logic      if_id_flush,
  output logic      id_ex_stall,
  output logic      id_ex_flush,
  output logic      ex_mem_stall,
  output logic      ex_mem_flush,

  output logic      retire_valid,
  output reg_addr_t retire_rd
);

  logic op_active_ex;

  rv_stage_if ex_stage ();
  rv_stage_if mem_stage ();
  rv_stage_if wb_stage ();

  // Stage metadata registers and the retire port
  rv_stage_regs stage_regs_i (
    .clk          (clk),
    .reset        (reset),
    .id_valid     (id_valid),
    .rd           (rd),
    .reg_write    (reg_write),
    .op           (op),
    .pc_stall     (pc_stall),
    .if_id_stall  (if_id_stall),
    .if_id_flush  (if_id_flush),
    .id_ex_stall  (id_ex_stall),
    .id_ex_flush  (id_ex_flush),
    .ex_mem_stall (ex_mem_stall),
    .ex_mem_flush (ex_mem_flush),
    .ex_stage     (ex_stage),
    .mem_stage    (mem_stage),
    .wb_stage     (wb_stage),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd)
  );

  // Keeps a divide in EX for its full latency
  rv_mdiv_timer #(
    .DIV_CYCLES (DIV_CYCLES)
  ) mdiv_timer_i (
    .clk          (clk),
    .reset        (reset),
    .ex_stage     (ex_stage),
    .op_active_ex (op_active_ex)
  );

  // Decides stalls and flushes from this cycle's stage contents
  rv_hazard #(
    .FWD         (FWD),
    .FWD_REGFILE (FWD_REGFILE),
    .MEM_TYPE    (MEM_TYPE)
  ) hazard_i (
    .rs1              (rs1),
    .rs2              (rs2),
    .rs1_used         (rs1_used),
    .rs2_used         (rs2_used),
    .ex_stage         (ex_stage),
    .mem_stage        (mem_stage),
    .wb_stage         (wb_stage),
    .op_active_ex     (op_active_ex),
    .pc_sel           (pc_sel),
    .mispredicted_mem (mispredicted_mem),
    .btb_pred_taken   (btb_pred_taken),
    .ras_pred_taken   (ras_pred_taken),
    .halt             (halt),
    .pc_stall         (pc_stall),
    .if_id_stall      (if_id_stall),
    .if_id_flush      (if_id_flush),
    .id_ex_stall      (id_ex_stall),
    .id_ex_flush      (id_ex_flush),
    .ex_mem_stall     (ex_mem_stall),
    .ex_mem_flush     (ex_mem_flush)
  );

endmodule

/* dv/rv_pipe_ctrl_tb.sv */
module rv_pipe_ctrl_tb
  import rv_pipe_pkg::*;
();

  // The DUT runs with its default parameters and these mirror the ones the checks rely on
  localparam int DIV_CYCLES   = 4;
  localparam int NUM_SCN      = 6;
  localparam int MAX_INS      = 10;
  localparam int NUM_CTL      = 7;
  localparam int DRAIN        = 8;
  localparam int HALT_LEN     = 5;
  localparam int RESET_CYCLES = 10;
  localparam int PERIOD       = 8;

  logic      clk;
  logic      reset;
  logic      id_valid;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rs1_used;
  logic      rs2_used;
  reg_addr_t rd;
  logic      reg_write;
  op_class_e op;
  pc_sel_e   pc_sel;
  logic      mispredicted_mem;
  logic      btb_pred_taken;
  logic      ras_pred_taken;
  logic      halt;
  logic      pc_stall;
  logic      if_id_stall;
  logic      if_id_flush;
  logic      id_ex_stall;
  logic      id_ex_flush;
  logic      ex_mem_stall;
  logic      ex_mem_flush;
  logic      retire_valid;
  reg_addr_t retire_rd;

  // Scenario table with one row of instructions per scenario
  op_class_e   ins_op   [NUM_SCN][MAX_INS];
  reg_addr_t   ins_rd   [NUM_SCN][MAX_INS];
  reg_addr_t   ins_rs1  [NUM_SCN][MAX_INS];
  reg_addr_t   ins_rs2  [NUM_SCN][MAX_INS];
  logic [1:0]  ins_use  [NUM_SCN][MAX_INS];
  bit          ins_fill [NUM_SCN][MAX_INS];
  bit          ins_keep [NUM_SCN][MAX_INS];
  string       scn_name [NUM_SCN];
  int          scn_len  [NUM_SCN];
  int          scn_redir[NUM_SCN];
  int          scn_mispr[NUM_SCN];
  int          scn_halt [NUM_SCN];
  int          exp_cnt  [NUM_SCN][NUM_CTL];

  int          cur;
  bit          table_ready;
  logic [31:0] rng;
  int          errors;
  int          checks;
  int          ctl_cnt[NUM_CTL];
  int          halt_retire_cnt;
  reg_addr_t   got_rd[$];
  reg_addr_t   exp_rd[$];

  rv_pipe_ctrl dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Stall and flush controls in the order they are counted
  function automatic string ctl_label(input int i);
    case (i)
      0:       return "pc_stall";
      1:       return "if_id_stall";
      2:       return "if_id_flush";
      3:       return "id_ex_stall";
      4:       return "id_ex_flush";
      5:       return "ex_mem_stall";
      default: return "ex_mem_flush";
    endcase
  endfunction

  // Starts a new row; -1 marks an event that does not happen
  task automatic open_scn(input string name, input int redir, input int mispr, input int hlt);
    cur = cur + 1;
    scn_name[cur]  = name;
    scn_len[cur]   = 0;
    scn_redir[cur] = redir;
    scn_mispr[cur] = mispr;
    scn_halt[cur]  = hlt;
  endtask

  // Cycles each control is expected high over the whole scenario
  task automatic expect_counts(input int pc_stl, input int ifid_stl, input int ifid_fl,
                               input int idex_stl, input int idex_fl, input int exmem_stl,
                               input int exmem_fl);
    exp_cnt[cur][0] = pc_stl;
    exp_cnt[cur][1] = ifid_stl;
    exp_cnt[cur][2] = ifid_fl;
    exp_cnt[cur][3] = idex_stl;
    exp_cnt[cur][4] = idex_fl;
    exp_cnt[cur][5] = exmem_stl;
    exp_cnt[cur][6] = exmem_fl;
  endtask

  task automatic add_ins(input op_class_e cls, input int dst, input int src1, input int src2,
                         input logic [1:0] use_mask, input bit keep);
    int k;
    k = scn_len[cur];
    ins_op[cur][k]   = cls;
    ins_rd[cur][k]   = reg_addr_t'(dst);
    ins_rs1[cur][k]  = reg_addr_t'(src1);
    ins_rs2[cur][k]  = reg_addr_t'(src2);
    ins_use[cur][k]  = use_mask;
    ins_fill[cur][k] = 1'b0;
    ins_keep[cur][k] = keep;
    scn_len[cur]     = k + 1;
  endtask

  // Filler reads nothing and its destination is drawn just before the run
  task automatic add_filler(input bit keep);
    add_ins(OP_ALU, 0, 0, 0, 2'b00, keep);
    ins_fill[cur][scn_len[cur] - 1] = 1'b1;
  endtask

  task automatic build_table();
    cur = -1;
    open_scn("independent alu", -1, -1, -1);
    expect_counts(0, 0, 0, 0, 0, 0, 0);
    repeat (6) add_filler(1'b1);
    // ALU to ALU is forwarded; load use waits in EX, in BRAM MEM and in WB
    // Each data hazard cycle holds IF/ID and puts a bubble into EX
    open_scn("alu and load use", -1, -1, -1);
    expect_counts(3, 3, 0, 0, 3, 0, 0);
    add_ins(OP_ALU, 1, 0, 0, 2'b00, 1'b1);
    add_ins(OP_ALU, 2, 1, 0, 2'b01, 1'b1);
    add_ins(OP_LOAD, 3, 0, 0, 2'b00, 1'b1);
    add_ins(OP_ALU, 4, 3, 0, 2'b01, 1'b1);
    // CSR use costs EX, MEM and WB; a WB distance use costs one; x0 costs nothing
    open_scn("csr, wb distance and x0", -1, -1, -1);
    expect_counts(4, 4, 0, 0, 4, 0, 0);
    add_ins(OP_CSR, 5, 0, 0, 2'b00, 1'b1);
    add_ins(OP_ALU, 6, 5, 0, 2'b01, 1'b1);
    add_ins(OP_ALU, 7, 0, 0, 2'b00, 1'b1);
    add_filler(1'b1);
    add_filler(1'b1);
    add_ins(OP_ALU, 9, 7, 0, 2'b01, 1'b1);
    add_ins(OP_LOAD, 0, 0, 0, 2'b00, 1'b1);
    add_ins(OP_ALU, 10, 0, 0, 2'b11, 1'b1);
    // The divide holds the front and ID/EX while MEM gets bubbles
    open_scn("divide", -1, -1, -1);
    expect_counts(DIV_CYCLES, DIV_CYCLES, 0, DIV_CYCLES, 0, 0, DIV_CYCLES);
    add_ins(OP_DIV, 8, 0, 0, 2'b00, 1'b1);
    repeat (3) add_filler(1'b1);
    // Redirect at 2 drops 2 and 3; mispredict at 6 drops 5, 6 and 7
    open_scn("redirect and mispredict", 2, 6, -1);
    expect_counts(0, 0, 2, 0, 2, 0, 1);
    for (int k = 0; k < 10; k++) begin
      add_filler(!(k inside {2, 3, 5, 6, 7}));
    end
    open_scn("halt", -1, -1, 2);
    expect_counts(HALT_LEN, HALT_LEN, 0, HALT_LEN, 0, HALT_LEN, 0);
    repeat (6) add_filler(1'b1);
  endtask

  function automatic bit reg_taken(input int s, input reg_addr_t r);
    for (int k = 0; k < scn_len[s]; k++) begin
      if (!ins_fill[s][k] && (r == ins_rd[s][k] || r == ins_rs1[s][k] || r == ins_rs2[s][k])) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Fillers land in x20 to x31 and avoid every register the scenario names
  task automatic pick_fillers(input int s);
    reg_addr_t r;
    for (int k = 0; k < scn_len[s]; k++) begin
      if (ins_fill[s][k]) begin
        do begin
          rng = xorshift32(rng);
          r   = reg_addr_t'(20 + rng % 12);
        end while (reg_taken(s, r));
        ins_rd[s][k] = r;
      end
    end
  endtask

  task automatic drive_ins(input int s, input int k);
    id_valid  <= 1'b1;
    rs1       <= ins_rs1[s][k];
    rs2       <= ins_rs2[s][k];
    rs1_used  <= ins_use[s][k][0];
    rs2_used  <= ins_use[s][k][1];
    rd        <= ins_rd[s][k];
    reg_write <= !(ins_op[s][k] inside {OP_STORE, OP_NOP});
    op        <= ins_op[s][k];
  endtask

  task automatic drive_idle();
    id_valid         <= 1'b0;
    rs1_used         <= 1'b0;
    rs2_used         <= 1'b0;
    reg_write        <= 1'b0;
    op               <= OP_NOP;
    pc_sel           <= PC_SEL_SEQ;
    mispredicted_mem <= 1'b0;
    halt             <= 1'b0;
  endtask

  // Called at the falling edge, where every output of the cycle is settled
  task automatic sample_outputs();
    logic [NUM_CTL-1:0] ctl;
    ctl = {ex_mem_flush, ex_mem_stall, id_ex_flush, id_ex_stall, if_id_flush, if_id_stall,
           pc_stall};
    for (int i = 0; i < NUM_CTL; i++) begin
      if (ctl[i]) begin
        ctl_cnt[i]++;
      end
    end
    if (retire_valid) begin
      got_rd.push_back(retire_rd);
      if (halt) begin
        halt_retire_cnt++;
      end
    end
  endtask

  task automatic run_scn(input int s);
    int idx;
    int halt_left;
    int err0;
    bit fresh;
    pick_fillers(s);
    err0 = errors;
    for (int i = 0; i < NUM_CTL; i++) begin
      ctl_cnt[i] = 0;
    end
    halt_retire_cnt = 0;
    got_rd.delete();
    exp_rd.delete();
    for (int k = 0; k < scn_len[s]; k++) begin
      if (ins_keep[s][k]) begin
        exp_rd.push_back(ins_rd[s][k]);
      end
    end
    idx       = 0;
    halt_left = 0;
    fresh     = 1'b1;
    while (idx < scn_len[s]) begin
      @(posedge clk);
      // Events fire on the first cycle their instruction sits in ID
      if (fresh && idx == scn_halt[s]) begin
        halt_left = HALT_LEN;
      end
      drive_ins(s, idx);
      pc_sel           <= (fresh && idx == scn_redir[s]) ? PC_SEL_REDIRECT : PC_SEL_SEQ;
      mispredicted_mem <= fresh && idx == scn_mispr[s];
      halt             <= (halt_left > 0);
      if (halt_left > 0) begin
        halt_left--;
      end
      @(negedge clk);
      sample_outputs();
      // A stalled front end keeps the same instruction in ID
      fresh = !pc_stall;
      if (!pc_stall) begin
        idx++;
      end
    end
    repeat (DRAIN) begin
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      sample_outputs();
    end
    check_equal(got_rd.size(), exp_rd.size(), {scn_name[s], " retire count"});
    for (int k = 0; k < exp_rd.size() && k < got_rd.size(); k++) begin
      check_equal(got_rd[k], exp_rd[k], $sformatf("%s retire %0d rd", scn_name[s], k));
    end
    for (int i = 0; i < NUM_CTL; i++) begin
      check_equal(ctl_cnt[i], exp_cnt[s][i], {scn_name[s], " ", ctl_label(i), " cycles"});
    end
    if (scn_halt[s] >= 0) begin
      check_equal(halt_retire_cnt, 0, {scn_name[s], " retires during halt"});
    end
    $display("scenario %0d (%s): %0d stall cycles, %0d retired, %s", s, scn_name[s],
             ctl_cnt[0], got_rd.size(), (errors == err0) ? "ok" : "mismatch");
  endtask

  // Budget covers reset, every scenario with its drain, one divide and one halt, doubled
  initial begin
    int limit;
    wait (table_ready);
    limit = RESET_CYCLES + DIV_CYCLES + HALT_LEN;
    for (int s = 0; s < NUM_SCN; s++) begin
      limit += scn_len[s] + DRAIN;
    end
    limit = limit * PERIOD * 2;
    #(limit);
    $display("watchdog expired: run did not finish within %0d time units", limit);
    $display("tests failed");
    $finish;
  end

  initial begin
    reset            = 1'b1;
    id_valid         = 1'b0;
    rs1              = REG_ZERO;
    rs2              = REG_ZERO;
    rs1_used         = 1'b0;
    rs2_used         = 1'b0;
    rd               = REG_ZERO;
    reg_write        = 1'b0;
    op               = OP_NOP;
    pc_sel           = PC_SEL_SEQ;
    mispredicted_mem = 1'b0;
    btb_pred_taken   = 1'b0;
    ras_pred_taken   = 1'b0;
    halt             = 1'b0;
    rng              = 32'd12637;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int s = 0; s < NUM_SCN; s++) begin
      run_scn(s);
    end
    $display("%0d scenarios, %0d checks, %0d errors", NUM_SCN, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
hdl/rv_pipe_pkg.sv
hdl/rv_stage_if.sv
hdl/rv_hazard.sv
hdl/rv_stage_regs.sv
hdl/rv_mdiv_timer.sv
hdl/rv_pipe_ctrl.sv
dv/rv_pipe_ctrl_tb.sv

/* Bender.yml */
package:
  name: rv_pipe_ctrl

sources:
  - hdl/rv_pipe_pkg.sv
  - hdl/rv_stage_if.sv
  - hdl/rv_hazard.sv
  - hdl/rv_stage_regs.sv
  - hdl/rv_mdiv_timer.sv
  - hdl/rv_pipe_ctrl.sv
  - target: test
    files:
      - dv/rv_pipe_ctrl_tb.sv
